//--- hdl/duckHunt_settings.svh
`ifndef DUCKHUNT_SETTINGS_SVH
`define DUCKHUNT_SETTINGS_SVH

// ========================================
// screen geometry, one pixel per Clk
// ========================================
`define H_ACTIVE      64
`define H_TOTAL       80
`define H_SYNC_START  68
`define H_SYNC_END    74
`define V_ACTIVE      48
`define V_TOTAL       52
`define V_SYNC_START  49
`define V_SYNC_END    51
`define COORD_W       7

// object boxes in pixels
`define DUCK_SIZE     6
`define DOG_W         10
`define DOG_H         6
`define CURSOR_SIZE   3
`define DOG_Y         40
`define DUCK_START_Y  36
// duck climb per frame, both axes
`define DUCK_STEP     2

// must not be zero
`define LFSR_SEED     16'hACE1

// palette and register map
`define PAL_DEPTH     16
`define COLOR_W       12
`define APB_ADDR_W    8
`define PAL_BASE      8'h40

`endif

//--- hdl/duckHuntPkg.sv
`include "duckHunt_settings.svh"

package duckHuntPkg;

	// ========================================
	// game flow
	// ========================================
	// one step per frame while run is set
	typedef enum logic [2:0] {
		idle,
		dogWalk,
		duckFly,
		duckHit,
		duckEscape
	} gameState_t;

	// ========================================
	// APB word addresses
	// ========================================
	// cursor: X in [6:0], Y in [22:16]
	// buttons: buttons in [2:0], run in bit 8
	// status: state in [2:0], score in [15:8]
	// palette window from palBase, one word per entry
	typedef enum logic [`APB_ADDR_W-1:0] {
		cursorReg  = 8'h00,
		buttonReg  = 8'h04,
		statusReg  = 8'h08,
		duckPosReg = 8'h0C,
		dogPosReg  = 8'h10,
		palBase    = `PAL_BASE
	} regAddr_t;

	// draw order, lowest first
	// code doubles as palette index
	typedef enum logic [1:0] {
		background,
		dog,
		duck,
		cursor
	} layer_t;

endpackage

//--- hdl/vgaTiming.sv
`timescale 1ns/100ps
`include "duckHunt_settings.svh"

module vgaTiming (
	input  logic                Clk,
	input  logic                arstN,
	output logic [`COORD_W-1:0] drawX,
	output logic [`COORD_W-1:0] drawY,
	output logic                hs,
	output logic                vs,
	output logic                blank,
	output logic                frameStart
);

	logic lineEnd;
	logic frameEnd;

	// ========================================
	// scan counters
	// ========================================
	assign lineEnd  = (drawX == `H_TOTAL - 1);
	assign frameEnd = lineEnd && (drawY == `V_TOTAL - 1);

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			drawX <= '0;
			drawY <= '0;
		end else begin
			// pixel counter wraps every line
			drawX <= lineEnd ? '0 : drawX + 1'b1;
			// line counter moves only at line end
			if (frameEnd) begin
				drawY <= '0;
			end else if (lineEnd) begin
				drawY <= drawY + 1'b1;
			end
		end
	end

	// ========================================
	// decoded timing
	// ========================================
	// syncs active low, inside blanking
	assign hs = !((drawX >= `H_SYNC_START) && (drawX < `H_SYNC_END));
	assign vs = !((drawY >= `V_SYNC_START) && (drawY < `V_SYNC_END));

	// anything outside the visible box
	assign blank = (drawX >= `H_ACTIVE) || (drawY >= `V_ACTIVE);

	// first pixel of the frame, one cycle
	assign frameStart = (drawX == '0) && (drawY == '0);

	// line length never overruns
	drawXRange: assert property (@(posedge Clk) disable iff (!arstN)
		drawX < `H_TOTAL);

endmodule

//--- hdl/hostRegs.sv
`timescale 1ns/100ps
`include "duckHunt_settings.svh"

module hostRegs (
	input  logic                            Clk,
	input  logic                            arstN,
	input  logic                            PSEL,
	input  logic                            PENABLE,
	input  logic                            PWRITE,
	input  logic [`APB_ADDR_W-1:0]          PADDR,
	input  logic [31:0]                     PWDATA,
	input  logic                            palWrGnt,
	input  duckHuntPkg::gameState_t         state,
	input  logic [7:0]                      score,
	input  logic [`COORD_W-1:0]             duckX,
	input  logic [`COORD_W-1:0]             duckY,
	input  logic [`COORD_W-1:0]             dogX,
	output logic [31:0]                     PRDATA,
	output logic                            PREADY,
	output logic                            PSLVERR,
	output logic [`COORD_W-1:0]             cursorX,
	output logic [`COORD_W-1:0]             cursorY,
	output logic                            fireBtn,
	output logic                            run,
	output logic                            palWrReq,
	output logic [$clog2(`PAL_DEPTH)-1:0]   palWrAddr,
	output logic [`COLOR_W-1:0]             palWrData
);

	import duckHuntPkg::*;

	localparam int padW = 16 - `COORD_W;
	localparam logic [`COORD_W-1:0] dogYPos = `DOG_Y;

	logic       access;
	logic       mapped;
	logic       readOnly;
	logic       palHit;
	logic       regWr;
	logic [2:0] btnReg;

	// ========================================
	// address decode and read mux
	// ========================================
	// access phase of any transfer
	assign access = PSEL && PENABLE;

	always_comb begin
		PRDATA   = '0;
		mapped   = 1'b1;
		readOnly = 1'b0;
		palHit   = 1'b0;
		case (regAddr_t'(PADDR))
			cursorReg:  PRDATA = {{padW{1'b0}}, cursorY, {padW{1'b0}}, cursorX};
			buttonReg:  PRDATA = {23'b0, run, 5'b0, btnReg};
			statusReg: begin
				PRDATA   = {16'b0, score, 5'b0, state};
				readOnly = 1'b1;
			end
			duckPosReg: begin
				PRDATA   = {{padW{1'b0}}, duckY, {padW{1'b0}}, duckX};
				readOnly = 1'b1;
			end
			dogPosReg: begin
				PRDATA   = {{padW{1'b0}}, dogYPos, {padW{1'b0}}, dogX};
				readOnly = 1'b1;
			end
			default: begin
				// palette window, word aligned, write only
				palHit = (PADDR >= palBase) && (PADDR < palBase + 4 * `PAL_DEPTH)
					&& (PADDR[1:0] == 2'b00);
				mapped = palHit;
			end
		endcase
	end

	// ========================================
	// APB response
	// ========================================
	// palette writes stall until the arbiter grants
	assign palWrReq  = access && PWRITE && palHit;
	assign palWrAddr = PADDR[$clog2(`PAL_DEPTH)+1:2];
	assign palWrData = PWDATA[`COLOR_W-1:0];

	assign PREADY  = access && (!palWrReq || palWrGnt);
	assign PSLVERR = access && (!mapped || (PWRITE && readOnly));

	// register writes finish in the access cycle
	assign regWr = access && PWRITE;

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			cursorX <= '0;
			cursorY <= '0;
			btnReg  <= '0;
			run     <= 1'b0;
			fireBtn <= 1'b0;
		end else begin
			fireBtn <= 1'b0;
			if (regWr && (PADDR == cursorReg)) begin
				cursorX <= PWDATA[`COORD_W-1:0];
				cursorY <= PWDATA[16 +: `COORD_W];
			end
			if (regWr && (PADDR == buttonReg)) begin
				btnReg <= PWDATA[2:0];
				run    <= PWDATA[8];
				// left button press, edge only
				fireBtn <= PWDATA[0] && !btnReg[0];
			end
		end
	end

	// a new palette request always follows a setup phase
	palReqAfterSetup: assert property (@(posedge Clk) disable iff (!arstN)
		$rose(palWrReq) |-> $past(PSEL && !PENABLE));

endmodule

//--- hdl/gameControl.sv
`timescale 1ns/100ps
`include "duckHunt_settings.svh"

module gameControl (
	input  logic                    Clk,
	input  logic                    arstN,
	input  logic                    frameStart,
	input  logic                    run,
	input  logic [`COORD_W-1:0]     cursorX,
	input  logic [`COORD_W-1:0]     cursorY,
	input  logic                    fireBtn,
	output logic [`COORD_W-1:0]     duckX,
	output logic [`COORD_W-1:0]     duckY,
	output logic [1:0]              duckColor,
	output logic [`COORD_W-1:0]     dogX,
	output logic                    showDuck,
	output logic                    showDog,
	output duckHuntPkg::gameState_t state,
	output logic [7:0]              score
);

	import duckHuntPkg::*;

	localparam logic [`COORD_W-1:0] duckStep  = `DUCK_STEP;
	localparam logic [`COORD_W-1:0] duckStart = `DUCK_START_Y;
	// duck leaves from the middle of the dog
	localparam logic [`COORD_W-1:0] duckOfs   = (`DOG_W - `DUCK_SIZE) / 2;
	localparam logic [`COORD_W-1:0] walkMin   = 8;

	logic [15:0]         lfsr;
	logic                lfsrFb;
	logic [`COORD_W-1:0] dogTarget;
	logic                duckRight;
	logic                onDuck;
	logic                hitPend;

	// ========================================
	// random source
	// ========================================
	// taps 16,14,13,11, maximal length
	assign lfsrFb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	// cursor hot spot inside duck box
	assign onDuck = (cursorX >= duckX) && (cursorX < duckX + `DUCK_SIZE)
		&& (cursorY >= duckY) && (cursorY < duckY + `DUCK_SIZE);

	// visibility follows the state
	assign showDog  = (state != idle);
	assign showDuck = (state == duckFly) || (state == duckHit);

	// ========================================
	// per-frame game step
	// ========================================
	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			lfsr      <= `LFSR_SEED;
			state     <= idle;
			score     <= '0;
			dogX      <= '0;
			dogTarget <= '0;
			duckX     <= '0;
			duckY     <= duckStart;
			duckColor <= '0;
			duckRight <= 1'b0;
			hitPend   <= 1'b0;
		end else begin
			// shots land any time, scored at next frame
			if (fireBtn && (state == duckFly) && onDuck) begin
				hitPend <= 1'b1;
			end
			if (frameStart) begin
				lfsr <= {lfsr[14:0], lfsrFb};
				if (run) begin
					case (state)
						// new round, dog enters from the left
						idle, duckHit, duckEscape: begin
							state     <= dogWalk;
							dogX      <= '0;
							dogTarget <= walkMin + lfsr[4:0];
						end
						dogWalk: begin
							if (dogX == dogTarget) begin
								state     <= duckFly;
								duckX     <= dogX + duckOfs;
								duckY     <= duckStart;
								duckRight <= lfsr[0];
								duckColor <= lfsr[2:1];
							end else begin
								dogX <= dogX + 1'b1;
							end
						end
						duckFly: begin
							if (hitPend) begin
								state   <= duckHit;
								score   <= score + 1'b1;
								hitPend <= 1'b0;
							end else if (duckY < duckStep) begin
								// next step would leave the top
								state <= duckEscape;
							end else begin
								duckY <= duckY - duckStep;
								// bounce off the side edges
								if (duckRight) begin
									if (duckX + `DUCK_SIZE + `DUCK_STEP > `H_ACTIVE) begin
										duckRight <= 1'b0;
										duckX     <= duckX - duckStep;
									end else begin
										duckX <= duckX + duckStep;
									end
								end else if (duckX < duckStep) begin
									duckRight <= 1'b1;
									duckX     <= duckX + duckStep;
								end else begin
									duckX <= duckX - duckStep;
								end
							end
						end
						default: state <= idle;
					endcase
				end
			end
		end
	end

	// a shown duck stays inside the visible width
	duckOnScreen: assert property (@(posedge Clk) disable iff (!arstN)
		showDuck |-> (duckX + `DUCK_SIZE <= `H_ACTIVE));

endmodule

//--- hdl/paletteArbiter.sv
`timescale 1ns/100ps
`include "duckHunt_settings.svh"

module paletteArbiter (
	input  logic                          Clk,
	input  logic                          arstN,
	input  logic                          rdEn,
	input  logic [$clog2(`PAL_DEPTH)-1:0] rdAddr,
	input  logic                          palWrReq,
	input  logic [$clog2(`PAL_DEPTH)-1:0] palWrAddr,
	input  logic [`COLOR_W-1:0]           palWrData,
	output logic [`COLOR_W-1:0]           rdData,
	output logic                          palWrGnt
);

	logic [`COLOR_W-1:0] mem [`PAL_DEPTH];

	// ========================================
	// fixed priority, renderer first
	// ========================================
	// host only gets the memory in blanking
	assign palWrGnt = palWrReq && !rdEn;

	// write port, palette starts all black
	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `PAL_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (palWrGnt) begin
			mem[palWrAddr] <= palWrData;
		end
	end

	// registered read, one cycle
	always_ff @(posedge Clk) begin
		if (rdEn) begin
			rdData <= mem[rdAddr];
		end
	end

	// a stalled write holds its entry and colour until granted
	wrHeldUntilGnt: assert property (@(posedge Clk) disable iff (!arstN)
		palWrReq && !palWrGnt |=> palWrReq && $stable(palWrAddr) && $stable(palWrData));

endmodule

//--- hdl/pixelRenderer.sv
`timescale 1ns/100ps
`include "duckHunt_settings.svh"

module pixelRenderer (
	input  logic                          Clk,
	input  logic                          arstN,
	input  logic [`COORD_W-1:0]           drawX,
	input  logic [`COORD_W-1:0]           drawY,
	input  logic                          hs,
	input  logic                          vs,
	input  logic                          blank,
	input  logic [`COORD_W-1:0]           cursorX,
	input  logic [`COORD_W-1:0]           cursorY,
	input  logic [`COORD_W-1:0]           duckX,
	input  logic [`COORD_W-1:0]           duckY,
	input  logic [1:0]                    duckColor,
	input  logic [`COORD_W-1:0]           dogX,
	input  logic                          showDuck,
	input  logic                          showDog,
	input  logic [`COLOR_W-1:0]           rdData,
	output logic                          rdEn,
	output logic [$clog2(`PAL_DEPTH)-1:0] rdAddr,
	output logic [3:0]                    VGA_R,
	output logic [3:0]                    VGA_G,
	output logic [3:0]                    VGA_B,
	output logic                          VGA_HS,
	output logic                          VGA_VS,
	output logic                          blankOut
);

	import duckHuntPkg::*;

	localparam int palAddrW = $clog2(`PAL_DEPTH);
	// second duck colour set sits 4 entries up
	localparam logic [palAddrW-1:0] altDuckOfs = 4;

	layer_t              layer;
	logic                onCursor;
	logic                onDuck;
	logic                onDog;
	logic                hs1;
	logic                vs1;
	logic                blank1;
	logic [`COLOR_W-1:0] color;

	// ========================================
	// stage one, layer pick and palette read
	// ========================================
	assign onCursor = (drawX >= cursorX) && (drawX < cursorX + `CURSOR_SIZE)
		&& (drawY >= cursorY) && (drawY < cursorY + `CURSOR_SIZE);
	assign onDuck = showDuck && (drawX >= duckX) && (drawX < duckX + `DUCK_SIZE)
		&& (drawY >= duckY) && (drawY < duckY + `DUCK_SIZE);
	assign onDog = showDog && (drawX >= dogX) && (drawX < dogX + `DOG_W)
		&& (drawY >= `DOG_Y) && (drawY < `DOG_Y + `DOG_H);

	// top layer wins
	always_comb begin
		if (onCursor) begin
			layer = cursor;
		end else if (onDuck) begin
			layer = duck;
		end else if (onDog) begin
			layer = dog;
		end else begin
			layer = background;
		end
	end

	// memory held only for visible pixels
	assign rdEn = !blank;
	assign rdAddr = {{(palAddrW - 2){1'b0}}, layer}
		+ (((layer == duck) && (duckColor != 2'b00)) ? altDuckOfs : '0);

	// ========================================
	// stage two, colour out with aligned syncs
	// ========================================
	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			hs1      <= 1'b1;
			vs1      <= 1'b1;
			blank1   <= 1'b1;
			VGA_HS   <= 1'b1;
			VGA_VS   <= 1'b1;
			blankOut <= 1'b1;
			color    <= '0;
		end else begin
			// first delay matches the memory read
			hs1    <= hs;
			vs1    <= vs;
			blank1 <= blank;
			VGA_HS   <= hs1;
			VGA_VS   <= vs1;
			blankOut <= blank1;
			// black outside the visible box
			color <= blank1 ? '0 : rdData;
		end
	end

	assign VGA_R = color[11:8];
	assign VGA_G = color[7:4];
	assign VGA_B = color[3:0];

endmodule

//--- hdl/duckHuntTop.sv
`timescale 1ns/100ps
`include "duckHunt_settings.svh"

module duckHuntTop (
	input  logic                   Clk,
	input  logic                   arstN,
	input  logic                   PSEL,
	input  logic                   PENABLE,
	input  logic                   PWRITE,
	input  logic [`APB_ADDR_W-1:0] PADDR,
	input  logic [31:0]            PWDATA,
	output logic [31:0]            PRDATA,
	output logic                   PREADY,
	output logic                   PSLVERR,
	output logic                   VGA_HS,
	output logic                   VGA_VS,
	output logic [3:0]             VGA_R,
	output logic [3:0]             VGA_G,
	output logic [3:0]             VGA_B,
	output logic                   blank
);

	import duckHuntPkg::*;

	// ========================================
	// internal nets
	// ========================================
	// scan position and timing
	logic [`COORD_W-1:0] drawX, drawY;
	logic                hs, vs, vgaBlank, frameStart;
	// host registers
	logic [`COORD_W-1:0] cursorX, cursorY;
	logic                fireBtn, run;
	// palette write path
	logic                          palWrReq, palWrGnt;
	logic [$clog2(`PAL_DEPTH)-1:0] palWrAddr;
	logic [`COLOR_W-1:0]           palWrData;
	// game objects
	logic [`COORD_W-1:0] duckX, duckY, dogX;
	logic [1:0]          duckColor;
	logic                showDuck, showDog;
	gameState_t          state;
	logic [7:0]          score;
	// palette read path
	logic                          rdEn;
	logic [$clog2(`PAL_DEPTH)-1:0] rdAddr;
	logic [`COLOR_W-1:0]           rdData;

	vgaTiming vgaTiming_i (
		.Clk, .arstN, .drawX, .drawY, .hs, .vs,
		.blank(vgaBlank), .frameStart
	);

	hostRegs hostRegs_i (
		.Clk, .arstN, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
		.palWrGnt, .state, .score, .duckX, .duckY, .dogX,
		.PRDATA, .PREADY, .PSLVERR, .cursorX, .cursorY, .fireBtn, .run,
		.palWrReq, .palWrAddr, .palWrData
	);

	gameControl gameControl_i (
		.Clk, .arstN, .frameStart, .run, .cursorX, .cursorY, .fireBtn,
		.duckX, .duckY, .duckColor, .dogX, .showDuck, .showDog, .state, .score
	);

	paletteArbiter paletteArbiter_i (
		.Clk, .arstN, .rdEn, .rdAddr, .palWrReq, .palWrAddr, .palWrData,
		.rdData, .palWrGnt
	);

	// blank leaves aligned with the colour
	pixelRenderer pixelRenderer_i (
		.Clk, .arstN, .drawX, .drawY, .hs, .vs, .blank(vgaBlank),
		.cursorX, .cursorY, .duckX, .duckY, .duckColor, .dogX,
		.showDuck, .showDog, .rdData, .rdEn, .rdAddr,
		.VGA_R, .VGA_G, .VGA_B, .VGA_HS, .VGA_VS, .blankOut(blank)
	);

endmodule

//--- testbench/duckHuntTb.sv
`timescale 1ns/100ps
`include "duckHunt_settings.svh"

module duckHuntTb;

	import duckHuntPkg::*;

	localparam int frameLen      = `H_TOTAL * `V_TOTAL;
	localparam int visiblePixels = `H_ACTIVE * `V_ACTIVE;
	// dog walk alone can last 40 frames, plus checked and set-up frames
	localparam int timeoutCycles = 64 * frameLen;

	// DUT ports
	logic                   Clk;
	logic                   arstN;
	logic                   PSEL;
	logic                   PENABLE;
	logic                   PWRITE;
	logic [`APB_ADDR_W-1:0] PADDR;
	logic [31:0]            PWDATA;
	logic [31:0]            PRDATA;
	logic                   PREADY;
	logic                   PSLVERR;
	logic                   VGA_HS;
	logic                   VGA_VS;
	logic [3:0]             VGA_R;
	logic [3:0]             VGA_G;
	logic [3:0]             VGA_B;
	logic                   blank;

	// screen model, filled from APB readback
	logic [`COLOR_W-1:0] palShadow [`PAL_DEPTH];
	int                  curX;
	int                  curY;
	int                  duckPosX;
	int                  duckPosY;
	int                  dogPosX;
	logic                showDuckM;
	logic                showDogM;
	logic                duckAlt;
	logic [2:0]          gState;
	logic [7:0]          gScore;

	// monitor state
	int   monX;
	int   monY;
	logic hsPrev;
	logic vsPrev;
	logic hsSeen;
	logic vsSeen;
	logic checkEn;
	int   pixCount;
	event frameEdge;

	// frame tracking and run control
	int          frameCycle;
	int          runCycles;
	logic [15:0] refLfsr;
	logic [15:0] lfsrUsed;
	event        frameTick;

	// test scratch
	logic [31:0] rdVal;
	logic        err;
	int          waits;
	int          flown;
	logic [2:0]  prevState;
	int          prevDogX;
	int          prevDuckX;
	int          prevDuckY;
	logic [11:0] palData;

	duckHuntTop duckHuntTop_i (
		.Clk, .arstN, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
		.PRDATA, .PREADY, .PSLVERR, .VGA_HS, .VGA_VS, .VGA_R, .VGA_G, .VGA_B, .blank
	);

	initial begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	// ========================================
	// reporting and reference
	// ========================================
	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else stopOnError($sformatf("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// layer rule, cursor over duck over dog over background
	function automatic logic [`COLOR_W-1:0] expectedColor(input int x, input int y);
		int idx;
		if ((x >= curX) && (x < curX + `CURSOR_SIZE) && (y >= curY)
			&& (y < curY + `CURSOR_SIZE)) begin
			idx = int'(cursor);
		end else if (showDuckM && (x >= duckPosX) && (x < duckPosX + `DUCK_SIZE)
			&& (y >= duckPosY) && (y < duckPosY + `DUCK_SIZE)) begin
			// second duck colour set 4 entries up
			idx = int'(duck) + (duckAlt ? 4 : 0);
		end else if (showDogM && (x >= dogPosX) && (x < dogPosX + `DOG_W)
			&& (y >= `DOG_Y) && (y < `DOG_Y + `DOG_H)) begin
			idx = int'(dog);
		end else begin
			idx = int'(background);
		end
		return palShadow[idx];
	endfunction

	// 16-bit maximal LFSR, taps 16,14,13,11
	function automatic logic [15:0] nextLfsr(input logic [15:0] v);
		return {v[14:0], v[15] ^ v[13] ^ v[12] ^ v[10]};
	endfunction

	// ========================================
	// APB master
	// ========================================
	task automatic apbTransfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic slvErr, output int waitCnt);
		@(negedge Clk);
		PSEL    = 1'b1;
		PENABLE = 1'b0;
		PWRITE  = wr;
		PADDR   = addr;
		PWDATA  = wdata;
		@(negedge Clk);
		PENABLE = 1'b1;
		waitCnt = 0;
		@(posedge Clk);
		// palette writes stall until blanking
		while (!PREADY) begin
			waitCnt++;
			@(posedge Clk);
		end
		rdata  = PRDATA;
		slvErr = PSLVERR;
		@(negedge Clk);
		PSEL    = 1'b0;
		PENABLE = 1'b0;
	endtask

	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic slvErr);
		logic [31:0] unused;
		int          waitCnt;
		apbTransfer(1'b1, addr, data, unused, slvErr, waitCnt);
	endtask

	// register reads end in the access cycle
	task automatic apbRead(input logic [7:0] addr, output logic [31:0] data);
		logic slvErr;
		int   waitCnt;
		apbTransfer(1'b0, addr, 32'h0, data, slvErr, waitCnt);
		checkValue("PSLVERR on read", slvErr, 1'b0);
		checkValue("read wait states", waitCnt, 0);
	endtask

	// state, score and object positions into the model
	task automatic readPositions();
		logic [31:0] d;
		apbRead(statusReg, d);
		gState = d[2:0];
		gScore = d[15:8];
		apbRead(duckPosReg, d);
		duckPosX = d[6:0];
		duckPosY = d[22:16];
		apbRead(dogPosReg, d);
		dogPosX = d[6:0];
		checkValue("dogY", d[22:16], `DOG_Y);
		apbRead(cursorReg, d);
		curX = d[6:0];
		curY = d[22:16];
		showDogM  = (gState != idle);
		showDuckM = (gState == duckFly) || (gState == duckHit);
	endtask

	task automatic waitFrame();
		@(frameTick);
	endtask

	// one whole frame compared pixel by pixel
	task automatic checkFrame();
		@(frameEdge);
		pixCount = 0;
		checkEn  = 1'b1;
		@(frameEdge);
		checkEn = 1'b0;
		checkValue("checked pixel count", pixCount, visiblePixels);
	endtask

	// ========================================
	// screen monitor
	// ========================================
	// coordinates rebuilt from the sync falling edges
	always @(posedge Clk) begin
		if (!arstN) begin
			hsSeen = 1'b0;
			vsSeen = 1'b0;
			hsPrev = 1'b1;
			vsPrev = 1'b1;
		end else begin
			if (hsPrev && !VGA_HS) begin
				monX   = `H_SYNC_START;
				hsSeen = 1'b1;
			end else begin
				monX = (monX + 1) % `H_TOTAL;
				if (monX == 0) begin
					monY = (monY + 1) % `V_TOTAL;
				end
			end
			if (vsPrev && !VGA_VS) begin
				monY   = `V_SYNC_START;
				vsSeen = 1'b1;
			end
			hsPrev = VGA_HS;
			vsPrev = VGA_VS;
			if (hsSeen && vsSeen) begin
				checkValue($sformatf("blank at (%0d,%0d)", monX, monY), blank,
					(monX >= `H_ACTIVE) || (monY >= `V_ACTIVE));
				checkValue($sformatf("VGA_HS at x %0d", monX), VGA_HS,
					!((monX >= `H_SYNC_START) && (monX < `H_SYNC_END)));
				checkValue($sformatf("VGA_VS at y %0d", monY), VGA_VS,
					!((monY >= `V_SYNC_START) && (monY < `V_SYNC_END)));
				if (checkEn && !blank) begin
					checkValue($sformatf("VGA colour at (%0d,%0d)", monX, monY),
						{VGA_R, VGA_G, VGA_B}, expectedColor(monX, monY));
					pixCount++;
				end
				if ((monX == 0) && (monY == 0)) begin
					-> frameEdge;
				end
			end
		end
	end

	// frame start cycles and the LFSR value each one consumes
	always @(posedge Clk) begin
		runCycles++;
		if (runCycles >= timeoutCycles) begin
			stopOnError($sformatf("simulation timed out after %0d cycles", runCycles));
		end
		if (!arstN) begin
			frameCycle = 0;
			refLfsr    = `LFSR_SEED;
		end else begin
			if (frameCycle % frameLen == 0) begin
				lfsrUsed = refLfsr;
				refLfsr  = nextLfsr(refLfsr);
				-> frameTick;
			end
			frameCycle++;
		end
	end

	// ========================================
	// tests
	// ========================================
	initial begin
		arstN     = 1'b0;
		PSEL      = 1'b0;
		PENABLE   = 1'b0;
		PWRITE    = 1'b0;
		PADDR     = '0;
		PWDATA    = '0;
		runCycles = 0;
		checkEn   = 1'b0;
		monX      = 0;
		monY      = 0;
		curX      = 0;
		curY      = 0;
		duckPosX  = 0;
		duckPosY  = 0;
		dogPosX   = 0;
		showDuckM = 1'b0;
		showDogM  = 1'b0;
		duckAlt   = 1'b0;
		for (int i = 0; i < `PAL_DEPTH; i++) begin
			palShadow[i] = '0;
		end
		void'($urandom(47));
		repeat (8) @(posedge Clk);
		@(negedge Clk);
		arstN = 1'b1;

		// 1 reset values, black screen
		checkValue("PREADY", PREADY, 1'b0);
		checkValue("VGA_HS", VGA_HS, 1'b1);
		checkValue("VGA_VS", VGA_VS, 1'b1);
		apbRead(statusReg, rdVal);
		checkValue("statusReg", rdVal, 32'h0);
		checkFrame();

		// 2 palette fill and error responses
		for (int i = 0; i < `PAL_DEPTH; i++) begin
			palData = $urandom();
			apbWrite(`PAL_BASE + 4 * i, {20'h0, palData}, err);
			checkValue("PSLVERR on palette write", err, 1'b0);
			palShadow[i] = palData;
		end
		apbWrite(statusReg, $urandom(), err);
		checkValue("PSLVERR on statusReg write", err, 1'b1);
		apbWrite(duckPosReg, $urandom(), err);
		checkValue("PSLVERR on duckPosReg write", err, 1'b1);
		apbWrite(dogPosReg, $urandom(), err);
		checkValue("PSLVERR on dogPosReg write", err, 1'b1);
		apbTransfer(1'b0, 8'h14, 32'h0, rdVal, err, waits);
		checkValue("PSLVERR on unmapped read", err, 1'b1);
		checkValue("unmapped read wait states", waits, 0);

		// 3 idle game, random cursor
		curX = $urandom() % `H_ACTIVE;
		curY = $urandom() % `V_ACTIVE;
		apbWrite(cursorReg, (curY << 16) | curX, err);
		rdVal = (curY << 16) | curX;
		readPositions();
		checkValue("cursorReg", (curY << 16) | curX, rdVal);
		checkFrame();

		// 4 run frame by frame until the duck has flown twice
		apbWrite(buttonReg, 32'h100, err);
		flown = 0;
		while (flown < 2) begin
			prevState = gState;
			prevDogX  = dogPosX;
			prevDuckX = duckPosX;
			prevDuckY = duckPosY;
			waitFrame();
			readPositions();
			case (prevState)
				idle: begin
					checkValue("state", gState, dogWalk);
					checkValue("dogX", dogPosX, 0);
				end
				dogWalk: begin
					if (gState == duckFly) begin
						// duck leaves from the middle of the dog
						checkValue("duckX", duckPosX, prevDogX + (`DOG_W - `DUCK_SIZE) / 2);
						checkValue("duckY", duckPosY, `DUCK_START_Y);
						checkValue("dogX", dogPosX, prevDogX);
						duckAlt = (lfsrUsed[2:1] != 2'b00);
						flown   = 1;
					end else begin
						checkValue("state", gState, dogWalk);
						checkValue("dogX", dogPosX, prevDogX + 1);
					end
				end
				duckFly: begin
					checkValue("state", gState, duckFly);
					checkValue("duckY", duckPosY, prevDuckY - `DUCK_STEP);
					assert ((duckPosX == prevDuckX + `DUCK_STEP)
						|| (duckPosX + `DUCK_STEP == prevDuckX))
					else stopOnError($sformatf("[ERROR] duckX got 0x%0h from 0x%0h",
						duckPosX, prevDuckX));
					flown++;
				end
				default: stopOnError("game state left the idle, dog walk, duck flight order");
			endcase
		end
		apbWrite(buttonReg, 32'h0, err);
		readPositions();
		checkFrame();

		// 5 shoot the paused duck, then one running frame
		checkValue("state", gState, duckFly);
		apbWrite(cursorReg, ((duckPosY + 1) << 16) | (duckPosX + 1), err);
		apbWrite(buttonReg, 32'h1, err);
		apbWrite(buttonReg, 32'h101, err);
		waitFrame();
		apbWrite(buttonReg, 32'h1, err);
		rdVal = gScore;
		readPositions();
		checkValue("state", gState, duckHit);
		checkValue("score", gScore, rdVal + 1);
		checkFrame();

		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+hdl
hdl/duckHuntPkg.sv
hdl/vgaTiming.sv
hdl/hostRegs.sv
hdl/gameControl.sv
hdl/paletteArbiter.sv
hdl/pixelRenderer.sv
hdl/duckHuntTop.sv
testbench/duckHuntTb.sv

//--- Bender.yml
package:
  name: duckHunt

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/duckHuntPkg.sv
      - hdl/vgaTiming.sv
      - hdl/hostRegs.sv
      - hdl/gameControl.sv
      - hdl/paletteArbiter.sv
      - hdl/pixelRenderer.sv
      - hdl/duckHuntTop.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - testbench/duckHuntTb.sv
